/* design/estimate_if.sv */
//////////////////////////////////////////////////////////////////////
// Estimate interface
// Predicted and corrected state vectors between the two datapaths
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

interface estimate_if import tracker_pkg::*; ();

	// Predicted state, written in the predict step
	state_vec_t x_next;

	// Corrected state, written in the update step
	state_vec_t x_curr;

	modport predictor (
		input  x_curr,
		output x_next
	);

	modport corrector (
		input  x_next,
		output x_curr
	);

endinterface

/* design/fixed_point_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Sign-magnitude fixed-point number format
// Word widths, the fix_t type and its arithmetic functions
//////////////////////////////////////////////////////////////////////

package fixed_point_pkg;

	localparam int ARCH_W = 38;
	localparam int ARCH_F = 15;
	localparam int MAG_W  = ARCH_W - 1;
	localparam int DISP_W = 11;

	// Sign in the top bit, magnitude below it
	typedef logic [ARCH_W-1:0] fix_t;

	localparam fix_t ONE_FI = fix_t'(1 << ARCH_F);

	// Magnitude product realigned to the binary point
	function automatic fix_t fix_mul(input fix_t a, input fix_t b);
		logic [2*MAG_W-1:0] full;
		logic [MAG_W-1:0]   mag;
		full = a[MAG_W-1:0] * b[MAG_W-1:0];
		mag  = full[ARCH_F +: MAG_W];
		return {(|mag) & (a[ARCH_W-1] ^ b[ARCH_W-1]), mag};
	endfunction

	function automatic fix_t fix_add(input fix_t a, input fix_t b);
		logic [MAG_W-1:0] mag_a;
		logic [MAG_W-1:0] mag_b;
		logic [MAG_W-1:0] mag;
		logic             sign;
		mag_a = a[MAG_W-1:0];
		mag_b = b[MAG_W-1:0];
		if (a[ARCH_W-1] == b[ARCH_W-1]) begin
			mag  = mag_a + mag_b;
			sign = a[ARCH_W-1];
		end else if (mag_a >= mag_b) begin
			mag  = mag_a - mag_b;
			sign = a[ARCH_W-1];
		end else begin
			mag  = mag_b - mag_a;
			sign = b[ARCH_W-1];
		end
		// Zero is always positive
		return {sign & (|mag), mag};
	endfunction

	function automatic fix_t fix_neg(input fix_t a);
		return (|a[MAG_W-1:0]) ? {~a[ARCH_W-1], a[MAG_W-1:0]} : a;
	endfunction

	// Unsigned display integer into the integer field
	function automatic fix_t to_fix(input logic [DISP_W-1:0] v);
		return fix_t'({v, {ARCH_F{1'b0}}});
	endfunction

endpackage

/* design/kalman_ctrl.sv */
//////////////////////////////////////////////////////////////////////
// Filter sequencer
// Valid/ready handshake and one strobe per filter step
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kalman_ctrl import tracker_pkg::*; (
	input  logic clk,
	input  logic aresetn,
	input  logic i_valid,
	output logic o_ready,
	output logic o_accept,
	output logic o_predict_en,
	output logic o_innovate_en,
	output logic o_update_en
);

	filter_state_e state_q;
	filter_state_e state_d;

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			state_q <= ST_INIT;
		end else begin
			state_q <= state_d;
		end
	end

	// One measurement in flight, three steps per accept
	always_comb begin
		unique case (state_q)
			ST_INIT:     state_d = ST_IDLE;
			ST_IDLE:     state_d = i_valid ? ST_PREDICT : ST_IDLE;
			ST_PREDICT:  state_d = ST_INNOVATE;
			ST_INNOVATE: state_d = ST_UPDATE;
			ST_UPDATE:   state_d = ST_IDLE;
			default:     state_d = ST_INIT;
		endcase
	end

	assign o_ready  = (state_q == ST_IDLE);
	assign o_accept = o_ready & i_valid;

	// Step strobes
	assign o_predict_en  = (state_q == ST_PREDICT);
	assign o_innovate_en = (state_q == ST_INNOVATE);
	assign o_update_en   = (state_q == ST_UPDATE);

endmodule

/* design/kalman_tracker.sv */
//////////////////////////////////////////////////////////////////////
// Two-axis position tracker top level
// Sequencer, predictor and corrector around one estimate interface
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kalman_tracker import fixed_point_pkg::*; (
	input  logic              clk,
	input  logic              aresetn,
	input  logic [DISP_W-1:0] i_z_x,
	input  logic [DISP_W-1:0] i_z_y,
	input  logic              i_valid,
	output logic              o_ready,
	output logic [DISP_W-1:0] o_z_x,
	output logic [DISP_W-1:0] o_z_y
);

	logic accept;
	logic predict_en;
	logic innovate_en;
	logic update_en;

	estimate_if u_est ();

	kalman_ctrl u_ctrl (
		.clk           (clk),
		.aresetn       (aresetn),
		.i_valid       (i_valid),
		.o_ready       (o_ready),
		.o_accept      (accept),
		.o_predict_en  (predict_en),
		.o_innovate_en (innovate_en),
		.o_update_en   (update_en)
	);

	state_predictor u_predictor (
		.clk          (clk),
		.aresetn      (aresetn),
		.i_predict_en (predict_en),
		.est          (u_est.predictor)
	);

	measurement_corrector u_corrector (
		.clk           (clk),
		.aresetn       (aresetn),
		.i_accept      (accept),
		.i_innovate_en (innovate_en),
		.i_update_en   (update_en),
		.i_z_x         (i_z_x),
		.i_z_y         (i_z_y),
		.est           (u_est.corrector),
		.o_z_x         (o_z_x),
		.o_z_y         (o_z_y)
	);

endmodule

/* design/measurement_corrector.sv */
//////////////////////////////////////////////////////////////////////
// Measurement correction
// Measurement latch, innovation register and gain correction
// Integer position outputs taken from the corrected state
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module measurement_corrector import fixed_point_pkg::*, tracker_pkg::*; (
	input  logic              clk,
	input  logic              aresetn,
	input  logic              i_accept,
	input  logic              i_innovate_en,
	input  logic              i_update_en,
	input  logic [DISP_W-1:0] i_z_x,
	input  logic [DISP_W-1:0] i_z_y,
	estimate_if.corrector     est,
	output logic [DISP_W-1:0] o_z_x,
	output logic [DISP_W-1:0] o_z_y
);

	// Steady-state gain, each measurement feeds its own position and velocity
	function automatic fix_t k_elem(input int r, input int c);
		if (r == c) begin
			return GAIN_POS_FI;
		end
		if (r == c + NUM_MEASUR) begin
			return GAIN_VEL_FI;
		end
		return '0;
	endfunction

	meas_vec_t  z_vec;
	meas_vec_t  y_vec;
	state_vec_t x_corr;

	//////////////////////////////////////////////////////////////////////
	// Measurement and innovation
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			z_vec <= '0;
		end else if (i_accept) begin
			z_vec[0] <= to_fix(i_z_x);
			z_vec[1] <= to_fix(i_z_y);
		end
	end

	// Measurement minus predicted position, positions sit first in the state
	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			y_vec <= '0;
		end else if (i_innovate_en) begin
			for (int m = 0; m < NUM_MEASUR; m++) begin
				y_vec[m] <= fix_add(z_vec[m], fix_neg(est.x_next[m]));
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Gain correction
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		fix_t gain_sum;
		for (int r = 0; r < NUM_STATES; r++) begin
			gain_sum  = fix_add(fix_mul(k_elem(r, 0), y_vec[0]),
			                    fix_mul(k_elem(r, 1), y_vec[1]));
			x_corr[r] = fix_add(est.x_next[r], gain_sum);
		end
	end

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			est.x_curr <= '0;
		end else if (i_update_en) begin
			est.x_curr <= x_corr;
		end
	end

	// Integer bits above the fraction, sign dropped
	assign o_z_x = est.x_curr[0][ARCH_F +: DISP_W];
	assign o_z_y = est.x_curr[1][ARCH_F +: DISP_W];

endmodule

/* design/state_predictor.sv */
//////////////////////////////////////////////////////////////////////
// State prediction
// Transition-matrix product and predicted state register
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module state_predictor import fixed_point_pkg::*, tracker_pkg::*; (
	input  logic           clk,
	input  logic           aresetn,
	input  logic           i_predict_en,
	estimate_if.predictor  est
);

	// Identity plus the time step coupling position to velocity
	function automatic fix_t f_elem(input int r, input int c);
		if (r == c) begin
			return ONE_FI;
		end
		if ((r == 0 && c == 2) || (r == 1 && c == 3)) begin
			return TSTEP_FI;
		end
		return '0;
	endfunction

	state_vec_t x_pred;

	//////////////////////////////////////////////////////////////////////
	// Row products and sums
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		fix_t prod [NUM_STATES];
		fix_t pair_lo;
		fix_t pair_hi;
		for (int r = 0; r < NUM_STATES; r++) begin
			for (int c = 0; c < NUM_STATES; c++) begin
				prod[c] = fix_mul(f_elem(r, c), est.x_curr[c]);
			end
			// Two pair sums, then their sum
			pair_lo   = fix_add(prod[0], prod[1]);
			pair_hi   = fix_add(prod[2], prod[3]);
			x_pred[r] = fix_add(pair_lo, pair_hi);
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Predicted state register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge aresetn) begin
		if (!aresetn) begin
			est.x_next <= '0;
		end else if (i_predict_en) begin
			est.x_next <= x_pred;
		end
	end

endmodule

/* design/tracker_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Constant-velocity tracking filter definitions
// State-space sizes, time step and steady-state gains
// Sequencer state enum and state and measurement vector types
//////////////////////////////////////////////////////////////////////

package tracker_pkg;

	import fixed_point_pkg::*;

	// State order is x, y, vx, vy
	localparam int NUM_STATES = 4;
	localparam int NUM_MEASUR = 2;

	// Time step of 1/32
	localparam fix_t TSTEP_FI = fix_t'(1024);

	// Steady-state gain, 0.5 on position and 0.125 on velocity
	localparam fix_t GAIN_POS_FI = ONE_FI >> 1;
	localparam fix_t GAIN_VEL_FI = ONE_FI >> 3;

	typedef fix_t [NUM_STATES-1:0] state_vec_t;
	typedef fix_t [NUM_MEASUR-1:0] meas_vec_t;

	typedef enum logic [2:0] {
		ST_INIT,
		ST_IDLE,
		ST_PREDICT,
		ST_INNOVATE,
		ST_UPDATE
	} filter_state_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile and run the tracker testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module tb_kalman_tracker; then
	echo "Verilator compile failed"
	exit 1
fi

sim_out=$(./obj_dir/Vtb_kalman_tracker)
sim_status=$?
printf '%s\n' "$sim_out"

if [ "$sim_status" -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST PASSED"; then
	exit 0
fi
exit 1

/* sim.f */
design/fixed_point_pkg.sv
design/tracker_pkg.sv
design/estimate_if.sv
design/kalman_ctrl.sv
design/state_predictor.sv
design/measurement_corrector.sv
design/kalman_tracker.sv
testbench/kalman_tracker_properties.sv
testbench/tb_kalman_tracker.sv

/* testbench/kalman_tracker_properties.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the filter sequencer
// Ready gap after accept, exclusive step strobes, accept only in ready
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module kalman_tracker_properties (
	input logic clk,
	input logic aresetn,
	input logic i_ready,
	input logic i_accept,
	input logic i_predict_en,
	input logic i_innovate_en,
	input logic i_update_en
);

	// Three busy cycles, then ready again
	property p_ready_gap;
		@(posedge clk) disable iff (!aresetn)
		i_accept |=> !i_ready ##1 !i_ready ##1 !i_ready ##1 i_ready;
	endproperty

	a_ready_gap: assert property (p_ready_gap)
		else $error("o_ready not low for exactly three cycles after an accept");

	a_one_step: assert property (@(posedge clk) disable iff (!aresetn)
		$onehot0({i_predict_en, i_innovate_en, i_update_en}))
		else $error("more than one step strobe high in the same cycle");

	a_accept_ready: assert property (@(posedge clk) disable iff (!aresetn)
		i_accept |-> i_ready)
		else $error("o_accept high while o_ready is low");

endmodule

/* testbench/tb_kalman_tracker.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the two-axis position tracker
// Clock, reset, random stimulus, reference filter model and checks
// Watchdog and binding of the sequencer properties
//////////////////////////////////////////////////////////////////////

`timescale 1ns/100ps

module tb_kalman_tracker import fixed_point_pkg::*, tracker_pkg::*; ();

	localparam int          CLK_PERIOD   = 20;
	localparam int          RESET_CYCLES = 3;
	localparam int          NUM_ACCEPTS  = 300;
	localparam int unsigned SEED         = 32'h13c4523e;
	// Bursts hold one measurement for accepts 40 to 79 of every hundred
	localparam int          BURST_START  = 40;
	localparam int          BURST_END    = 79;
	localparam int          WALK_MIN     = 16;
	localparam int          WALK_MAX     = 2031;

	logic              clk = 1'b0;
	logic              aresetn;
	logic [DISP_W-1:0] i_z_x;
	logic [DISP_W-1:0] i_z_y;
	logic              i_valid;
	logic              o_ready;
	logic [DISP_W-1:0] o_z_x;
	logic [DISP_W-1:0] o_z_y;

	fix_t mdl_x [NUM_STATES];
	fix_t f_mat [NUM_STATES][NUM_STATES];
	fix_t k_mat [NUM_STATES][NUM_MEASUR];
	int   errors = 0;
	int   checks = 0;
	int   accepts = 0;
	int   walk_x = 100;
	int   walk_y = 100;
	int   hold_x = 0;
	int   hold_y = 0;

	kalman_tracker u_dut (
		.clk     (clk),
		.aresetn (aresetn),
		.i_z_x   (i_z_x),
		.i_z_y   (i_z_y),
		.i_valid (i_valid),
		.o_ready (o_ready),
		.o_z_x   (o_z_x),
		.o_z_y   (o_z_y)
	);

	bind kalman_ctrl kalman_tracker_properties u_props (
		.clk           (clk),
		.aresetn       (aresetn),
		.i_ready       (o_ready),
		.i_accept      (o_accept),
		.i_predict_en  (o_predict_en),
		.i_innovate_en (o_innovate_en),
		.i_update_en   (o_update_en)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic void build_matrices();
		for (int r = 0; r < NUM_STATES; r++) begin
			for (int c = 0; c < NUM_STATES; c++) begin
				f_mat[r][c] = (r == c) ? ONE_FI : '0;
			end
			k_mat[r][0] = '0;
			k_mat[r][1] = '0;
			mdl_x[r]    = '0;
		end
		f_mat[0][2] = TSTEP_FI;
		f_mat[1][3] = TSTEP_FI;
		k_mat[0][0] = GAIN_POS_FI;
		k_mat[1][1] = GAIN_POS_FI;
		k_mat[2][0] = GAIN_VEL_FI;
		k_mat[3][1] = GAIN_VEL_FI;
	endfunction

	// Predict, innovate and correct on one accepted pair
	function automatic void filter_step(input logic [DISP_W-1:0] zx, input logic [DISP_W-1:0] zy);
		fix_t pred [NUM_STATES];
		fix_t innov [NUM_MEASUR];
		fix_t lo;
		fix_t hi;
		fix_t corr;
		for (int r = 0; r < NUM_STATES; r++) begin
			lo = fix_add(fix_mul(f_mat[r][0], mdl_x[0]), fix_mul(f_mat[r][1], mdl_x[1]));
			hi = fix_add(fix_mul(f_mat[r][2], mdl_x[2]), fix_mul(f_mat[r][3], mdl_x[3]));
			pred[r] = fix_add(lo, hi);
		end
		innov[0] = fix_add(to_fix(zx), fix_neg(pred[0]));
		innov[1] = fix_add(to_fix(zy), fix_neg(pred[1]));
		for (int r = 0; r < NUM_STATES; r++) begin
			corr = fix_add(fix_mul(k_mat[r][0], innov[0]), fix_mul(k_mat[r][1], innov[1]));
			mdl_x[r] = fix_add(pred[r], corr);
		end
	endfunction

	// Integer bits of the position magnitude
	function automatic int estimate_bits(input int axis);
		return int'(mdl_x[axis][ARCH_F +: DISP_W]);
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	function automatic int step_walk(input int pos);
		int next;
		next = pos + int'($urandom % 7) - 3;
		if (next < WALK_MIN) begin
			next = WALK_MIN;
		end
		if (next > WALK_MAX) begin
			next = WALK_MAX;
		end
		return next;
	endfunction

	// Pure noise whenever valid is low
	task automatic drive_inputs();
		logic valid;
		int   slot;
		valid  = (($urandom % 2) == 1);
		slot   = accepts % 100;
		walk_x = step_walk(walk_x);
		walk_y = step_walk(walk_y);
		i_valid <= valid;
		if (!valid) begin
			i_z_x <= DISP_W'($urandom);
			i_z_y <= DISP_W'($urandom);
		end else if (slot >= BURST_START && slot <= BURST_END) begin
			i_z_x <= DISP_W'(hold_x);
			i_z_y <= DISP_W'(hold_y);
		end else begin
			i_z_x <= DISP_W'(walk_x);
			i_z_y <= DISP_W'(walk_y);
		end
	endtask

	task automatic compare_value(input string name, input int got, input int exp);
		checks++;
		assert (got == exp) else begin
			errors++;
			$display("FAIL at %0d ns: %s is %0d, expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic require(input bit cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Error at %0d ns: %s", $time, what);
		end
	endtask

	initial begin
		int busy;
		bit waiting;
		bit settle_due;
		int shown_x;
		int shown_y;
		void'($urandom(SEED));
		build_matrices();
		busy       = 0;
		waiting    = 1'b0;
		settle_due = 1'b0;
		shown_x    = 0;
		shown_y    = 0;
		aresetn = 1'b0;
		i_valid = 1'b0;
		i_z_x   = '0;
		i_z_y   = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		aresetn <= 1'b1;
		@(negedge clk);
		require(!o_ready, "o_ready is high in the first cycle after reset release");
		@(negedge clk);
		require(o_ready, "o_ready did not rise one cycle after reset release");
		compare_value("o_z_x", int'(o_z_x), 0);
		compare_value("o_z_y", int'(o_z_y), 0);
		while (accepts < NUM_ACCEPTS || waiting) begin
			@(posedge clk);
			drive_inputs();
			@(negedge clk);
			if (waiting && o_ready) begin
				waiting = 1'b0;
				compare_value("o_ready low cycles", busy, 3);
				shown_x = estimate_bits(0);
				shown_y = estimate_bits(1);
			end else if (waiting) begin
				busy++;
			end else begin
				require(o_ready, "o_ready is low with no measurement in flight");
			end
			// Estimate held between updates
			compare_value("o_z_x", int'(o_z_x), shown_x);
			compare_value("o_z_y", int'(o_z_y), shown_y);
			if (!waiting && settle_due) begin
				settle_due = 1'b0;
				require(int'(o_z_x) >= hold_x - 2 && int'(o_z_x) <= hold_x + 2,
					$sformatf("x estimate %0d not within 2 of held %0d", o_z_x, hold_x));
				require(int'(o_z_y) >= hold_y - 2 && int'(o_z_y) <= hold_y + 2,
					$sformatf("y estimate %0d not within 2 of held %0d", o_z_y, hold_y));
			end
			if (o_ready && i_valid) begin
				filter_step(i_z_x, i_z_y);
				settle_due = ((accepts % 100) == BURST_END);
				accepts++;
				if ((accepts % 100) == BURST_START) begin
					hold_x = walk_x + int'($urandom % 17) - 8;
					hold_y = walk_y + int'($urandom % 17) - 8;
				end
				waiting = 1'b1;
				busy    = 0;
			end
		end
		$display("Summary: %0d accepts, %0d checks, %0d errors", accepts, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// Ten cycles per accept is about twice the expected run
	initial begin
		#((NUM_ACCEPTS * 10 + RESET_CYCLES + 2) * CLK_PERIOD);
		$display("Timeout: %0d of %0d measurements accepted before the limit", accepts,
			NUM_ACCEPTS);
		$display("TEST FAILED");
		$finish;
	end

endmodule
